//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_router_port
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- chan_rx.sv
`timescale 1ns/100ps

module chan_rx (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         in_req,
	input  flit_pkg::flit_t              in_flit,
	input  logic                         pkt_free,
	output logic                         in_ack,
	output logic                         wr_en,
	output logic [flit_pkg::ADDR_W-1:0]  wr_addr,
	output flit_pkg::flit_t              wr_flit,
	output logic                         pkt_full
);

	logic [flit_pkg::ADDR_W-1:0] cnt;
	logic                        req_q;
	logic                        pending;
	logic                        accept;

	// req_q holds the last accepted in_req level
	assign pending = in_req ^ req_q;

	// back-pressure: a pending flit waits while the slot is occupied
	assign accept = pending & ~pkt_full;

	// write straight from the channel, the neighbour holds in_flit stable
	assign wr_en   = accept;
	assign wr_addr = cnt;
	assign wr_flit = in_flit;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			req_q    <= 1'b0;
			in_ack   <= 1'b0;
			cnt      <= '0;
			pkt_full <= 1'b0;
		end else begin
			if (accept) begin
				req_q  <= in_req;
				in_ack <= ~in_ack;
				// counter wraps back to 0 after flit 7
				cnt    <= cnt + flit_pkg::ADDR_W'(1);
				if (cnt == flit_pkg::LAST_FLIT) begin
					pkt_full <= 1'b1;
				end
			end else if (pkt_free) begin
				// packet has left through a transmitter
				pkt_full <= 1'b0;
			end
		end
	end

endmodule

//--- chan_tx.sv
`timescale 1ns/100ps

module chan_tx (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         sw_req,
	input  flit_pkg::flit_t              buf_data,
	input  logic                         ch_ack,
	output logic                         sw_gnt,
	output logic [flit_pkg::ADDR_W-1:0]  buf_addr,
	output logic                         ch_req,
	output flit_pkg::flit_t              ch_flit
);

	logic                        state;
	logic [flit_pkg::ADDR_W-1:0] cnt;
	logic                        ack_q;
	logic                        ack_seen;
	logic                        start;
	logic                        advance;
	logic                        finish;

	// two-phase: any change of ch_ack accepts the flit on the channel
	assign ack_seen = ch_ack ^ ack_q;

	assign start = (state == flit_pkg::TX_IDLE) && sw_req;

	// cnt is the next word to fetch, it wraps to 0 once flit 7 is loaded
	assign advance = (state == flit_pkg::TX_SENDING) && ack_seen && (cnt != '0);
	assign finish  = (state == flit_pkg::TX_SENDING) && ack_seen && (cnt == '0);

	assign buf_addr = cnt;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state  <= flit_pkg::TX_IDLE;
			cnt    <= '0;
			ack_q  <= 1'b0;
			ch_req <= 1'b0;
			sw_gnt <= 1'b0;
		end else begin
			ack_q <= ch_ack;
			if (start) begin
				// grant and first flit leave on the same edge
				state  <= flit_pkg::TX_SENDING;
				sw_gnt <= 1'b1;
				ch_req <= ~ch_req;
				cnt    <= cnt + flit_pkg::ADDR_W'(1);
			end else if (advance) begin
				ch_req <= ~ch_req;
				cnt    <= cnt + flit_pkg::ADDR_W'(1);
			end else if (finish) begin
				// eighth ack seen, end of transfer for route_ctrl
				state  <= flit_pkg::TX_IDLE;
				sw_gnt <= 1'b0;
			end
		end
	end

	// flit register, loaded together with each req toggle
	always_ff @(posedge clk) begin
		if (start || advance) begin
			ch_flit <= buf_data;
		end
	end

endmodule

//--- flit_pkg.sv
package flit_pkg;

	// flit and packet sizes, fixed by the channel protocol
	localparam int FLIT_W    = 16;
	localparam int PKT_FLITS = 8;
	localparam int ADDR_W    = 3;
	localparam int NODE_W    = 4;

	// address of the flit that closes a packet
	localparam logic [ADDR_W-1:0] LAST_FLIT = 3'd7;

	// this router's place in the mesh
	localparam logic [NODE_W-1:0] NODE_ADDR = 4'h5;

	// output port indices, also the buffer read select
	localparam logic PORT_WEST = 1'b0;
	localparam logic PORT_EAST = 1'b1;

	// route_ctrl state codes
	localparam logic [1:0] RC_IDLE      = 2'd0;
	localparam logic [1:0] RC_REQUEST   = 2'd1;
	localparam logic [1:0] RC_WAIT_DONE = 2'd2;
	localparam logic [1:0] RC_RELEASE   = 2'd3;

	// chan_tx state codes
	localparam logic TX_IDLE    = 1'b0;
	localparam logic TX_SENDING = 1'b1;

	// flit 0 carries routing info, flits 1..7 are plain payload
	typedef union packed {
		struct packed {
			logic [NODE_W-1:0] dest;
			logic [NODE_W-1:0] src;
			logic [7:0]        seq;
		} head;
		struct packed {
			logic [FLIT_W-1:0] payload;
		} body;
	} flit_t;

endpackage

//--- pkt_buffer.sv
`timescale 1ns/100ps

module pkt_buffer (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         wr_en,
	input  logic [flit_pkg::ADDR_W-1:0]  wr_addr,
	input  flit_pkg::flit_t              wr_flit,
	input  logic                         out_sel,
	input  logic [flit_pkg::ADDR_W-1:0]  west_addr,
	input  logic [flit_pkg::ADDR_W-1:0]  east_addr,
	output flit_pkg::flit_t              rd_flit,
	output flit_pkg::flit_t              head_flit
);

	flit_pkg::flit_t             mem [flit_pkg::PKT_FLITS];
	logic [flit_pkg::ADDR_W-1:0] rd_addr;

	// only the granted transmitter gets the read port
	assign rd_addr = (out_sel == flit_pkg::PORT_EAST) ? east_addr : west_addr;

	// asynchronous read, the transmitter samples it on its load edge
	assign rd_flit = mem[rd_addr];

	// word 0 is the head flit, seen by the router logic
	assign head_flit = mem[0];

	// cleared on reset so the head view never decodes garbage
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < flit_pkg::PKT_FLITS; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[wr_addr] <= wr_flit;
		end
	end

endmodule

//--- route_ctrl.sv
`timescale 1ns/100ps

module route_ctrl (
	input  logic            clk,
	input  logic            reset,
	input  logic            pkt_full,
	input  flit_pkg::flit_t head_flit,
	input  logic            west_gnt,
	input  logic            east_gnt,
	output logic            west_sw_req,
	output logic            east_sw_req,
	output logic            out_sel,
	output logic            pkt_free
);

	logic [1:0] state;
	logic       go_east;
	logic       sel_gnt;
	logic       both_idle;

	// XY style rule along one axis: higher node ids sit to the east
	assign go_east = (head_flit.head.dest > flit_pkg::NODE_ADDR);

	// grant of the transmitter we are talking to
	assign sel_gnt = (out_sel == flit_pkg::PORT_EAST) ? east_gnt : west_gnt;

	// four-phase rule, no new request until the old grant is gone
	assign both_idle = ~west_gnt & ~east_gnt;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state       <= flit_pkg::RC_IDLE;
			out_sel     <= flit_pkg::PORT_WEST;
			west_sw_req <= 1'b0;
			east_sw_req <= 1'b0;
			pkt_free    <= 1'b0;
		end else begin
			case (state)
				flit_pkg::RC_IDLE: begin
					if (pkt_full && both_idle) begin
						// out_sel stays fixed for the whole transfer
						if (go_east) begin
							out_sel     <= flit_pkg::PORT_EAST;
							east_sw_req <= 1'b1;
						end else begin
							out_sel     <= flit_pkg::PORT_WEST;
							west_sw_req <= 1'b1;
						end
						state <= flit_pkg::RC_REQUEST;
					end
				end
				flit_pkg::RC_REQUEST: begin
					// transmitter took the packet, withdraw the request
					if (sel_gnt) begin
						west_sw_req <= 1'b0;
						east_sw_req <= 1'b0;
						state       <= flit_pkg::RC_WAIT_DONE;
					end
				end
				flit_pkg::RC_WAIT_DONE: begin
					// grant falls after the eighth output ack
					if (!sel_gnt) begin
						pkt_free <= 1'b1;
						state    <= flit_pkg::RC_RELEASE;
					end
				end
				flit_pkg::RC_RELEASE: begin
					// one-cycle pulse, chan_rx drops pkt_full on this edge
					pkt_free <= 1'b0;
					state    <= flit_pkg::RC_IDLE;
				end
				default: begin
					state <= flit_pkg::RC_IDLE;
				end
			endcase
		end
	end

endmodule

//--- router_port.sv
`timescale 1ns/100ps

module router_port (
	input  logic            clk,
	input  logic            reset,
	input  logic            in_req,
	input  flit_pkg::flit_t in_flit,
	input  logic            west_ack,
	input  logic            east_ack,
	output logic            in_ack,
	output logic            west_req,
	output flit_pkg::flit_t west_flit,
	output logic            east_req,
	output flit_pkg::flit_t east_flit
);

	// buffer write side
	logic                        wr_en;
	logic [flit_pkg::ADDR_W-1:0] wr_addr;
	flit_pkg::flit_t             wr_flit;

	// buffer read side
	logic [flit_pkg::ADDR_W-1:0] west_addr;
	logic [flit_pkg::ADDR_W-1:0] east_addr;
	flit_pkg::flit_t             rd_flit;
	flit_pkg::flit_t             head_flit;
	logic                        out_sel;

	// control
	logic pkt_full;
	logic pkt_free;
	logic west_sw_req;
	logic east_sw_req;
	logic west_gnt;
	logic east_gnt;

	chan_rx rx_i (
		.clk      (clk),
		.reset    (reset),
		.in_req   (in_req),
		.in_flit  (in_flit),
		.pkt_free (pkt_free),
		.in_ack   (in_ack),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_flit  (wr_flit),
		.pkt_full (pkt_full)
	);

	pkt_buffer buf_i (
		.clk       (clk),
		.reset     (reset),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_flit   (wr_flit),
		.out_sel   (out_sel),
		.west_addr (west_addr),
		.east_addr (east_addr),
		.rd_flit   (rd_flit),
		.head_flit (head_flit)
	);

	route_ctrl ctrl_i (
		.clk         (clk),
		.reset       (reset),
		.pkt_full    (pkt_full),
		.head_flit   (head_flit),
		.west_gnt    (west_gnt),
		.east_gnt    (east_gnt),
		.west_sw_req (west_sw_req),
		.east_sw_req (east_sw_req),
		.out_sel     (out_sel),
		.pkt_free    (pkt_free)
	);

	// both see rd_flit, only the requested one is ever granted
	chan_tx west_tx (
		.clk      (clk),
		.reset    (reset),
		.sw_req   (west_sw_req),
		.buf_data (rd_flit),
		.ch_ack   (west_ack),
		.sw_gnt   (west_gnt),
		.buf_addr (west_addr),
		.ch_req   (west_req),
		.ch_flit  (west_flit)
	);

	chan_tx east_tx (
		.clk      (clk),
		.reset    (reset),
		.sw_req   (east_sw_req),
		.buf_data (rd_flit),
		.ch_ack   (east_ack),
		.sw_gnt   (east_gnt),
		.buf_addr (east_addr),
		.ch_req   (east_req),
		.ch_flit  (east_flit)
	);

endmodule

//--- router_port_assert.sv
`timescale 1ns/100ps

module router_port_assert (
	input logic clk,
	input logic reset,
	input logic in_req,
	input logic in_ack,
	input logic west_req,
	input logic west_ack,
	input logic east_req,
	input logic east_ack
);

	// ack follows the req level, so in_ack may only move on an open request
	in_ack_on_pending: assert property (
		@(posedge clk) disable iff (reset)
		(in_ack != $past(in_ack)) |-> ($past(in_req) != $past(in_ack))
	) else $error("in_ack toggled with no pending in_req");

	// req == ack means the last flit was accepted
	west_one_toggle: assert property (
		@(posedge clk) disable iff (reset)
		(west_req != $past(west_req)) |-> ($past(west_req) == $past(west_ack))
	) else $error("west_req toggled again before west_ack");

	east_one_toggle: assert property (
		@(posedge clk) disable iff (reset)
		(east_req != $past(east_req)) |-> ($past(east_req) == $past(east_ack))
	) else $error("east_req toggled again before east_ack");

	west_quiet_in_reset: assert property (
		@(posedge clk) (reset && $past(reset)) |-> (west_req == $past(west_req))
	) else $error("west_req moved during reset");

	east_quiet_in_reset: assert property (
		@(posedge clk) (reset && $past(reset)) |-> (east_req == $past(east_req))
	) else $error("east_req moved during reset");

endmodule

bind router_port router_port_assert assert_i (
	.clk      (clk),
	.reset    (reset),
	.in_req   (in_req),
	.in_ack   (in_ack),
	.west_req (west_req),
	.west_ack (west_ack),
	.east_req (east_req),
	.east_ack (east_ack)
);

//--- tb_router_port.sv
`timescale 1ns/100ps

module tb_router_port;

	localparam int NUM_PKTS        = 40;
	localparam int ACK_LIMIT       = 2000;
	localparam int SINK_IDLE_LIMIT = 50000;
	localparam int SETTLE_CYCLES   = 16;
	localparam logic [31:0] SEED   = 32'hfac;

	logic            clk = 1'b0;
	logic            reset;
	logic            in_req;
	flit_pkg::flit_t in_flit;
	logic            west_ack;
	logic            east_ack;
	logic            in_ack;
	logic            west_req;
	flit_pkg::flit_t west_flit;
	logic            east_req;
	flit_pkg::flit_t east_flit;

	// expected output flits with the port in bit 16
	logic [16:0] model_q[$];
	int          acks_cnt [2] = '{0, 0};
	logic [31:0] src_lfsr = SEED;
	logic [31:0] sink_lfsr [2] = '{SEED, SEED};

	always #4 clk = ~clk;

	router_port dut_i (
		.clk       (clk),
		.reset     (reset),
		.in_req    (in_req),
		.in_flit   (in_flit),
		.west_ack  (west_ack),
		.east_ack  (east_ack),
		.in_ack    (in_ack),
		.west_req  (west_req),
		.west_flit (west_flit),
		.east_req  (east_req),
		.east_flit (east_flit)
	);

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end else begin
			return s >> 1;
		end
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			st  = lfsr_next(st);
			val = {val[30:0], st[0]};
		end
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	function automatic logic out_req(input logic port);
		return port ? east_req : west_req;
	endfunction

	// neighbour source sending one packet over the two-phase input channel
	task automatic send_packet(input int p);
		flit_pkg::flit_t flits [flit_pkg::PKT_FLITS];
		logic [31:0]     val;
		logic            port;
		int              waited;
		draw_bits(src_lfsr, 4, val);
		flits[0].head.dest = val[3:0];
		flits[0].head.src  = flit_pkg::NODE_ADDR - 4'h1;
		draw_bits(src_lfsr, 8, val);
		flits[0].head.seq = val[7:0];
		for (int i = 1; i < flit_pkg::PKT_FLITS; i++) begin
			draw_bits(src_lfsr, 16, val);
			flits[i].body.payload = val[15:0];
		end
		// higher destinations lie east and the rest west
		port = (flits[0].head.dest > flit_pkg::NODE_ADDR) ? flit_pkg::PORT_EAST
			: flit_pkg::PORT_WEST;
		for (int i = 0; i < flit_pkg::PKT_FLITS; i++) begin
			model_q.push_back({port, flits[i]});
		end
		for (int i = 0; i < flit_pkg::PKT_FLITS; i++) begin
			draw_bits(src_lfsr, 2, val);
			repeat (val) @(posedge clk);
			@(posedge clk);
			in_flit <= flits[i];
			in_req  <= ~in_req;
			waited = 0;
			@(negedge clk);
			while (in_ack != in_req) begin
				@(negedge clk);
				waited++;
				if (waited > ACK_LIMIT) begin
					fail_run($sformatf("in_ack never answered flit %0d of packet %0d", i, p));
				end
			end
			// single slot so the head waits for all acks of the previous packet
			if (i == 0) begin
				check("output acks before head accept", acks_cnt[0] + acks_cnt[1], 8 * p);
			end
		end
	endtask

	// output neighbour taking a flit per req toggle and acking after a random delay
	task automatic serve_sink(input logic port);
		logic        req_seen;
		logic [31:0] delay;
		logic [16:0] exp;
		logic [15:0] got;
		int          waited;
		string       req_name;
		string       flit_name;
		req_name  = port ? "east_req" : "west_req";
		flit_name = port ? "east_flit" : "west_flit";
		req_seen  = 1'b0;
		@(negedge clk);
		forever begin
			waited = 0;
			while (out_req(port) == req_seen) begin
				@(negedge clk);
				waited++;
				if (waited > SINK_IDLE_LIMIT) begin
					fail_run($sformatf("%s stayed idle too long", req_name));
				end
			end
			req_seen = out_req(port);
			got      = port ? east_flit : west_flit;
			if (model_q.size() == 0) begin
				fail_run($sformatf("unexpected flit 0x%h on %s", got, flit_name));
			end else begin
				exp = model_q.pop_front();
				check("output port", 32'(port), 32'(exp[16]));
				check(flit_name, 32'(got), 32'(exp[15:0]));
			end
			draw_bits(sink_lfsr[port], 4, delay);
			repeat (delay) begin
				@(negedge clk);
				check(req_name, 32'(out_req(port)), 32'(req_seen));
			end
			@(posedge clk);
			if (port) begin
				east_ack <= ~east_ack;
			end else begin
				west_ack <= ~west_ack;
			end
			acks_cnt[port]++;
		end
	endtask

	initial serve_sink(flit_pkg::PORT_WEST);
	initial serve_sink(flit_pkg::PORT_EAST);

	initial begin : stimulus
		int waited;
		reset    = 1'b1;
		in_req   = 1'b0;
		in_flit  = '0;
		west_ack = 1'b0;
		east_ack = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		// channels stay quiet until the first input flit
		repeat (4) begin
			@(negedge clk);
			check("in_ack", 32'(in_ack), 32'h0);
			check("west_req", 32'(west_req), 32'h0);
			check("east_req", 32'(east_req), 32'h0);
		end
		for (int p = 0; p < NUM_PKTS; p++) begin
			send_packet(p);
		end
		waited = 0;
		while (acks_cnt[0] + acks_cnt[1] != NUM_PKTS * flit_pkg::PKT_FLITS) begin
			@(negedge clk);
			waited++;
			if (waited > ACK_LIMIT) begin
				fail_run("last packet never left the router");
			end
		end
		// room for a surplus flit to show up after the last ack
		repeat (SETTLE_CYCLES) @(negedge clk);
		check("west_req", 32'(west_req), 32'(west_ack));
		check("east_req", 32'(east_req), 32'(east_ack));
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- vlog.f
flit_pkg.sv
chan_rx.sv
pkt_buffer.sv
route_ctrl.sv
chan_tx.sv
router_port.sv
router_port_assert.sv
tb_router_port.sv
